// ==== hw/histBuilder.sv ====
`timescale 1ns/1ps
`default_nettype none

module histBuilder
    import sifhPkg::*;
(
    input  wire logic     clk,
    input  wire logic     res,
    input  wire logic     clearStart,
    input  wire binEventT binEvent,
    input  wire countT    accReadData,
    output binT           accReadAddr,
    output ramWriteT      ramWrite,
    output logic          busy
);

    logic     clearing;                     // sweep in progress
    logic     s1Valid;                      // read stage
    binT      s1Bin;
    ramWriteT wr;                           // write stage, drives the RAM
    ramWriteT wrPrev;                       // write issued one cycle earlier
    countT    baseCount;
    countT    newCount;
    logic     lastClearAddr;

    // read is issued in the same cycle as the event
    assign accReadAddr = binEvent.bin;

    assign ramWrite = wr;

    assign lastClearAddr = (wr.addr == binT'(numBins - 1));

    // the RAM data is stale when one of the two previous events hit
    // the same bin, so take the newest pending value instead
    always_comb begin
        if (wr.en && (wr.addr == s1Bin)) begin
            baseCount = wr.data;            // event one cycle older
        end else if (wrPrev.en && (wrPrev.addr == s1Bin)) begin
            baseCount = wrPrev.data;        // event two cycles older
        end else begin
            baseCount = accReadData;
        end
    end

    always_comb begin
        if (baseCount == countMax) begin
            newCount = baseCount;           // saturate
        end else begin
            newCount = baseCount + countT'(1);
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid <= 1'b0;
            s1Bin   <= '0;
        end else begin
            s1Valid <= binEvent.valid;
            s1Bin   <= binEvent.bin;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            clearing <= 1'b0;
            wr       <= '0;
        end else begin
            if (clearStart) begin
                clearing <= 1'b1;
                wr.en    <= 1'b1;
                wr.addr  <= '0;
                wr.data  <= '0;
            end else if (clearing) begin
                if (lastClearAddr) begin
                    clearing <= 1'b0;
                    wr.en    <= 1'b0;
                end else begin
                    wr.addr <= wr.addr + binT'(1);
                end
                wr.data <= '0;
            end else begin
                wr.en   <= s1Valid;         // increment and write stage
                wr.addr <= s1Bin;
                wr.data <= newCount;
            end
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            wrPrev <= '0;
        end else begin
            wrPrev <= wr;                   // follows wr, never stale
        end
    end

    // covers the clear request, the sweep and both pipeline stages
    assign busy = clearStart || clearing || s1Valid || wr.en;

endmodule

`default_nettype wire

// ==== hw/histRam.sv ====
`timescale 1ns/1ps
`default_nettype none

module histRam
    import sifhPkg::*;
(
    input  wire logic     clk,
    input  wire ramWriteT ramWrite,
    input  wire binT      accReadAddr,
    input  wire binT      scanReadAddr,
    output countT         accReadData,
    output countT         scanReadData
);

    countT mem [numBins];                   // contents set by clear sweep

    always_ff @(posedge clk) begin
        if (ramWrite.en) begin
            mem[ramWrite.addr] <= ramWrite.data;
        end
    end

    // read ports return the value before a same-cycle write
    always_ff @(posedge clk) begin
        accReadData <= mem[accReadAddr];    // builder side
    end

    always_ff @(posedge clk) begin
        scanReadData <= mem[scanReadAddr];  // peak search side
    end

endmodule

`default_nettype wire

// ==== hw/peakFinder.sv ====
`timescale 1ns/1ps
`default_nettype none

module peakFinder
    import sifhPkg::*;
(
    input  wire logic  clk,
    input  wire logic  res,
    input  wire logic  searchStart,
    input  wire countT scanReadData,
    output binT        scanReadAddr,
    output logic       searchDone,
    output peakT       peak
);

    logic scanning;                         // address phase active
    logic dataValid;                        // RAM data belongs to dataBin
    logic dataLast;
    binT  dataBin;
    peakT best;
    peakT nextBest;
    logic greater;

    // strict compare keeps the lowest bin on a tie
    assign greater = dataValid && (scanReadData > best.count);

    always_comb begin
        if (greater) begin
            nextBest.bin   = dataBin;
            nextBest.count = scanReadData;
        end else begin
            nextBest = best;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            scanning     <= 1'b0;
            scanReadAddr <= '0;
        end else if (searchStart) begin
            scanning     <= 1'b1;
            scanReadAddr <= '0;
        end else if (scanning) begin
            if (scanReadAddr == binT'(numBins - 1)) begin
                scanning <= 1'b0;
            end else begin
                scanReadAddr <= scanReadAddr + binT'(1);
            end
        end
    end

    // one cycle behind the address because the RAM read is registered
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            dataValid <= 1'b0;
            dataLast  <= 1'b0;
            dataBin   <= '0;
        end else begin
            dataValid <= scanning;
            dataLast  <= scanning && (scanReadAddr == binT'(numBins - 1));
            dataBin   <= scanReadAddr;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            best       <= '0;
            peak       <= '0;
            searchDone <= 1'b0;
        end else begin
            if (searchStart) begin
                best <= '0;                 // fresh maximum per search
            end else begin
                best <= nextBest;
            end
            searchDone <= dataLast;
            if (dataLast) begin
                peak <= nextBest;           // includes the last bin
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/sifhControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module sifhControl
    import sifhPkg::*;
#(
    parameter int stampsPerPass = 200
) (
    input  wire logic  clk,
    input  wire logic  res,
    input  wire logic  start,
    input  wire stampT stamp,
    input  wire logic  stampValid,
    input  wire logic  busy,
    input  wire logic  searchDone,
    input  wire peakT  peak,
    output logic       tdcEnable,
    output logic       clearStart,
    output binEventT   binEvent,
    output logic       searchStart,
    output logic       done,
    output stampT      peakStamp,
    output countT      peakCount
);

    localparam int shotW = $clog2(stampsPerPass + 1);

    ctrlStateT        state;
    logic [shotW-1:0] shotCount;            // accepted stamps this pass
    binT              filterBin;            // coarse window for pass 2
    logic             accept;
    logic             finePass;
    binT              coarseBin;
    binT              fineBin;
    logic             lastShot;

    assign accept    = stampValid && tdcEnable;
    assign finePass  = (state == sBuild2);
    assign coarseBin = stamp[stampW-1:binW];
    assign fineBin   = stamp[binW-1:0];
    assign lastShot  = (shotCount == shotW'(stampsPerPass - 1));

    // pass 1 counts everything, pass 2 only stamps inside the window
    assign binEvent.valid = accept && (!finePass || (coarseBin == filterBin));
    assign binEvent.bin   = finePass ? fineBin : coarseBin;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state       <= sIdle;
            tdcEnable   <= 1'b0;
            clearStart  <= 1'b0;
            searchStart <= 1'b0;
            done        <= 1'b0;
            shotCount   <= '0;
            filterBin   <= '0;
            peakStamp   <= '0;
            peakCount   <= '0;
        end else begin
            clearStart  <= 1'b0;            // pulses by default
            searchStart <= 1'b0;
            done        <= 1'b0;
            if (accept) begin
                shotCount <= shotCount + shotW'(1);
                if (lastShot) begin
                    tdcEnable <= 1'b0;      // pass complete
                end
            end
            case (state)
                sIdle: begin
                    if (start) begin
                        clearStart <= 1'b1;
                        state      <= sClear1;
                    end
                end
                sClear1, sClear2: begin
                    if (!busy) begin
                        tdcEnable <= 1'b1;
                        shotCount <= '0;
                        state     <= (state == sClear1) ? sBuild1 : sBuild2;
                    end
                end
                sBuild1, sBuild2: begin
                    if (!tdcEnable && !busy) begin // last event written
                        searchStart <= 1'b1;
                        state       <= (state == sBuild1) ? sFind1 : sFind2;
                    end
                end
                sFind1: begin
                    if (searchDone) begin
                        state <= sFilter;
                    end
                end
                sFilter: begin
                    filterBin  <= peak.bin;
                    clearStart <= 1'b1;
                    state      <= sClear2;
                end
                sFind2: begin
                    if (searchDone) begin
                        peakStamp <= {filterBin, peak.bin};
                        peakCount <= peak.count;
                        done      <= 1'b1;
                        state     <= sReport;
                    end
                end
                sReport: begin
                    state <= sIdle;         // done is high here
                end
                default: begin
                    state <= sIdle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/sifhPkg.sv ====
`default_nettype none

package sifhPkg;

    parameter int stampW  = 12;             // full TDC timestamp
    parameter int binW    = 6;              // half a stamp
    parameter int countW  = 10;
    parameter int numBins = 64;

    typedef logic [stampW-1:0] stampT;
    typedef logic [binW-1:0]   binT;
    typedef logic [countW-1:0] countT;

    localparam countT countMax = {countW{1'b1}}; // counts saturate here

    typedef enum logic [3:0] {
        sIdle,
        sClear1,                            // zero memory before coarse pass
        sBuild1,
        sFind1,
        sFilter,                            // take coarse peak as window
        sClear2,
        sBuild2,
        sFind2,
        sReport
    } ctrlStateT;

    // one accepted stamp, already reduced to its bin
    typedef struct packed {
        logic valid;
        binT  bin;
    } binEventT;

    typedef struct packed {
        logic  en;
        binT   addr;
        countT data;
    } ramWriteT;

    typedef struct packed {
        binT   bin;
        countT count;
    } peakT;

endpackage

`default_nettype wire

// ==== hw/sifhTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module sifhTop
    import sifhPkg::*;
#(
    parameter int stampsPerPass = 200
) (
    input  wire logic  clk,
    input  wire logic  res,
    input  wire logic  start,
    input  wire stampT stamp,
    input  wire logic  stampValid,
    output logic       tdcEnable,
    output logic       done,
    output stampT      peakStamp,
    output countT      peakCount
);

    logic     clearStart;
    logic     busy;
    binEventT binEvent;
    ramWriteT ramWrite;
    binT      accReadAddr;
    countT    accReadData;
    binT      scanReadAddr;
    countT    scanReadData;
    logic     searchStart;
    logic     searchDone;
    peakT     peak;

    sifhControl #(
        .stampsPerPass(stampsPerPass)
    ) control_i (
        .clk        (clk),
        .res        (res),
        .start      (start),
        .stamp      (stamp),
        .stampValid (stampValid),
        .busy       (busy),
        .searchDone (searchDone),
        .peak       (peak),
        .tdcEnable  (tdcEnable),
        .clearStart (clearStart),
        .binEvent   (binEvent),
        .searchStart(searchStart),
        .done       (done),
        .peakStamp  (peakStamp),
        .peakCount  (peakCount)
    );

    histBuilder builder_i (
        .clk        (clk),
        .res        (res),
        .clearStart (clearStart),
        .binEvent   (binEvent),
        .accReadData(accReadData),
        .accReadAddr(accReadAddr),
        .ramWrite   (ramWrite),
        .busy       (busy)
    );

    histRam ram_i (
        .clk         (clk),
        .ramWrite    (ramWrite),
        .accReadAddr (accReadAddr),
        .scanReadAddr(scanReadAddr),
        .accReadData (accReadData),
        .scanReadData(scanReadData)
    );

    peakFinder finder_i (
        .clk         (clk),
        .res         (res),
        .searchStart (searchStart),
        .scanReadData(scanReadData),
        .scanReadAddr(scanReadAddr),
        .searchDone  (searchDone),
        .peak        (peak)
    );

endmodule

`default_nettype wire

// ==== test/sifhTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sifhTb
    import sifhPkg::*;
();

    localparam int tbStamps       = 1030;   // above the count limit
    localparam int satValue       = 1023;
    localparam int numMeas        = 6;
    localparam int watchdogCycles = numMeas * (2 * tbStamps * 4 + 400);
    localparam int modeRandom     = 0;
    localparam int modeCluster    = 1;
    localparam int modeFilter     = 2;
    localparam int modeSaturate   = 3;
    localparam int modeGating     = 4;

    logic   clk;
    logic   res;
    logic   start;
    stampT  stamp;
    logic   stampValid;
    logic   tdcEnable;
    logic   done;
    stampT  peakStamp;
    countT  peakCount;

    integer seed = 32'h6ec7_b032;
    int     coarseHist [numBins];           // model of pass 1
    int     fineHist [numBins];             // model of pass 2
    int     acceptCount;
    binT    modelFilter;
    stampT  expStamp;
    countT  expCount;
    binT    stampHi;
    binT    stampLo;

    assign stampHi = stamp[stampW-1:binW];
    assign stampLo = stamp[binW-1:0];

    sifhTop #(
        .stampsPerPass(tbStamps)
    ) dut_i (
        .clk       (clk),
        .res       (res),
        .start     (start),
        .stamp     (stamp),
        .stampValid(stampValid),
        .tdcEnable (tdcEnable),
        .done      (done),
        .peakStamp (peakStamp),
        .peakCount (peakCount)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("timeout: measurements not finished after %0d cycles", watchdogCycles);
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

    // lowest bin wins a tie
    function automatic int peakBin(input int hist [numBins]);
        int best;
        best = 0;
        for (int i = 1; i < numBins; i++) begin
            if (hist[i] > hist[best]) begin
                best = i;
            end
        end
        return best;
    endfunction

    // inputs are stable at the falling edge, so sample acceptance there
    always @(negedge clk) begin
        if (res && tdcEnable && stampValid) begin
            if (acceptCount < tbStamps) begin
                if (coarseHist[stampHi] < satValue) begin
                    coarseHist[stampHi]++;
                end
            end else if (stampHi == modelFilter) begin
                if (fineHist[stampLo] < satValue) begin
                    fineHist[stampLo]++;
                end
            end
            acceptCount++;
            if (acceptCount == tbStamps) begin
                modelFilter = binT'(peakBin(coarseHist)); // window for pass 2
            end
        end
    end

    task automatic checkValue(input string name, input int actual, input int wanted);
        if (actual != wanted) begin
            $display("ERROR at %0t: %s is %0d, expected %0d", $time, name, actual, wanted);
            $display(">>> FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic resetModel();
        for (int i = 0; i < numBins; i++) begin
            coarseHist[i] = 0;
            fineHist[i]   = 0;
        end
        acceptCount = 0;
        modelFilter = '0;
    endtask

    task automatic driveStamp(input int mode, input stampT center);
        binT hi;
        binT lo;
        hi = binT'($random(seed));
        lo = binT'($random(seed));
        case (mode)
            modeCluster: begin
                stampValid = (($random(seed) & 7) != 0);  // often back to back
                if (($random(seed) & 3) != 0) begin
                    stamp = center + stampT'($random(seed) & 3);
                end else begin
                    stamp = {hi, lo};
                end
            end
            modeFilter: begin
                stampValid = (($random(seed) & 1) != 0);
                if (acceptCount < tbStamps) begin
                    stamp = (($random(seed) & 3) != 0) ? {center[stampW-1:binW], lo} : {hi, lo};
                end else begin
                    stamp = (($random(seed) & 7) == 0) ? {modelFilter, lo} : {hi, lo};
                end
            end
            modeSaturate: begin
                stampValid = 1'b1;
                stamp      = center;
            end
            default: begin
                stampValid = (($random(seed) & 1) != 0);
                stamp      = {hi, lo};
            end
        endcase
    endtask

    task automatic runMeasurement(input int mode);
        stampT center;
        logic  seenDone;
        int    cycle;
        int    fineBin;
        resetModel();
        center   = stampT'($random(seed));
        seenDone = 1'b0;
        cycle    = 0;
        start    = 1'b1;
        while (!seenDone) begin
            driveStamp(mode, center);
            @(posedge clk);
            #10;
            start    = 1'b0;
            cycle++;
            seenDone = done;
            if (!seenDone && mode == modeGating && cycle > 2 && ($random(seed) & 63) == 0) begin
                start = 1'b1;               // busy sequencer must ignore it
            end
        end
        stampValid = 1'b0;
        fineBin    = peakBin(fineHist);
        expStamp   = {modelFilter, binT'(fineBin)};
        expCount   = countT'(fineHist[fineBin]);
        checkValue("acceptCount", acceptCount, 2 * tbStamps);
        checkValue("peakStamp", peakStamp, expStamp);
        checkValue("peakCount", peakCount, expCount);
        if (mode == modeSaturate) begin
            checkValue("peakCount", peakCount, satValue);
            checkValue("peakStamp", peakStamp, center);
        end
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            stampValid = (($random(seed) & 1) != 0); // gated off, no effect
            stamp      = stampT'($random(seed));
            @(posedge clk);
            #10;
            checkValue("tdcEnable", tdcEnable, 0);
        end
        stampValid = 1'b0;
        checkValue("peakStamp", peakStamp, expStamp);  // result held
        checkValue("peakCount", peakCount, expCount);
    endtask

    initial begin
        res        = 1'b0;
        start      = 1'b0;
        stamp      = '0;
        stampValid = 1'b0;
        expStamp   = '0;
        expCount   = '0;
        resetModel();
        repeat (5) @(posedge clk);
        #10;
        res = 1'b1;
        checkValue("tdcEnable", tdcEnable, 0);
        checkValue("done", done, 0);
        checkValue("busy", dut_i.busy, 0);
        checkValue("searchDone", dut_i.searchDone, 0);
        checkValue("ramWrite.en", dut_i.ramWrite.en, 0);
        idleCycles(10);
        runMeasurement(modeRandom);
        idleCycles(20);
        runMeasurement(modeCluster);
        idleCycles(20);
        runMeasurement(modeFilter);
        idleCycles(20);
        runMeasurement(modeSaturate);
        idleCycles(20);
        runMeasurement(modeGating);
        idleCycles(20);
        runMeasurement(modeRandom);         // restart after the gated run
        idleCycles(5);
        if (dut_i.assert_i.failCount != 0) begin
            $display("%0d assertion failures during the run", dut_i.assert_i.failCount);
            $display(">>> FAIL");
            $fatal(1, "assertion failures");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== test/sifhTop_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module sifhTop_assertions
    import sifhPkg::*;
(
    input wire logic     clk,
    input wire logic     res,
    input wire logic     done,
    input wire logic     tdcEnable,
    input wire logic     clearStart,
    input wire logic     busy,
    input wire ramWriteT ramWrite,
    input wire logic     searchStart,
    input wire logic     searchDone
);

    int unsigned failCount = 0;             // read by the testbench at the end
    logic        scanActive;                // searchStart seen, searchDone not yet
    logic        clearActive;               // clear requested, builder still busy

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            scanActive  <= 1'b0;
            clearActive <= 1'b0;
        end else begin
            if (searchStart) begin
                scanActive <= 1'b1;
            end else if (searchDone) begin
                scanActive <= 1'b0;
            end
            if (clearStart) begin
                clearActive <= 1'b1;
            end else if (!busy) begin
                clearActive <= 1'b0;
            end
        end
    end

    doneSinglePulse: assert property (@(posedge clk) disable iff (!res) done |=> !done)
        else begin
            failCount++;
            $error("done was high in two consecutive cycles");
        end

    noWriteDuringScan: assert property (@(posedge clk) disable iff (!res)
        scanActive |-> !ramWrite.en)
        else begin
            failCount++;
            $error("RAM written while the peak search runs");
        end

    gatedDuringClear: assert property (@(posedge clk) disable iff (!res)
        (clearStart || (clearActive && busy)) |-> !tdcEnable)
        else begin
            failCount++;
            $error("tdcEnable high during a clear sweep");
        end

endmodule

bind sifhTop sifhTop_assertions assert_i (
    .clk        (clk),
    .res        (res),
    .done       (done),
    .tdcEnable  (tdcEnable),
    .clearStart (clearStart),
    .busy       (busy),
    .ramWrite   (ramWrite),
    .searchStart(searchStart),
    .searchDone (searchDone)
);

`default_nettype wire

// ==== vlog.f ====
hw/sifhPkg.sv
hw/histRam.sv
hw/histBuilder.sv
hw/peakFinder.sv
hw/sifhControl.sv
hw/sifhTop.sv
test/sifhTop_assertions.sv
test/sifhTb.sv
